// ==== verilog/fpu_config.svh ====
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// operand and result word
`define FPU_DATA_W 64

// one single-precision lane
`define FPU_HALF_W 32

// ieee double fields
`define FPU_EXP_W 11
`define FPU_FRAC_W 52

`define FPU_FLAG_W 5

`define FPU_OP_W 4

// forward source code, late bit sits above it
`define FPU_SRC_W 2

// result buses from other units
`define FPU_NUM_BUS 2

`endif

// ==== verilog/fpu_pkg.sv ====
`default_nettype none
`include "fpu_config.svh"

package fpu_pkg;

  // unused codes decode as op_and
  typedef enum logic [`FPU_OP_W-1:0] {
    op_and,
    op_or,
    op_xor,
    op_andn,
    op_swap,
    op_dup_lo,
    op_merge,
    op_cmp_ord,
    op_cmp_unord
  } fpu_op_t;

  typedef enum logic [`FPU_SRC_W-1:0] {
    src_reg,
    src_bus0,
    src_bus1,
    src_self
  } fwd_src_t;

  typedef struct packed {
    logic     late;
    fwd_src_t src;
  } fwd_sel_t;

  typedef struct packed {
    logic                   valid;
    fpu_op_t                op;
    logic [`FPU_DATA_W-1:0] a;
    logic [`FPU_DATA_W-1:0] b;
    fwd_sel_t               sel_a;
    fwd_sel_t               sel_b;
  } fpu_issue_t;

  typedef enum logic [1:0] {
    unit_logic,
    unit_perm,
    unit_cmp
  } fpu_unit_t;

  typedef enum logic [1:0] {
    lf_and,
    lf_or,
    lf_xor,
    lf_andn
  } logic_fn_t;

  typedef enum logic [1:0] {
    pf_swap,
    pf_dup_lo,
    pf_merge
  } perm_fn_t;

  typedef struct packed {
    logic      valid;
    fpu_unit_t unit;
    logic_fn_t lfn;
    perm_fn_t  pfn;
    logic      ordered;
  } fpu_ctrl_t;

  // invalid in bit 0, lines up with the fpcsr mask field
  typedef struct packed {
    logic underflow;
    logic overflow;
    logic divzero;
    logic denormal;
    logic invalid;
  } fp_flags_t;

  typedef struct packed {
    fp_flags_t flags;
    logic      trap;
  } fpu_report_t;

  typedef struct packed {
    logic zf;
    logic pf;
    logic cf;
  } cmp_cc_t;

endpackage

`default_nettype wire

// ==== verilog/operand_forward.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "fpu_config.svh"

module operand_forward (
  input  wire                                     clk,
  input  wire                                     rst,
  input  wire [`FPU_DATA_W-1:0]                   reg_val,
  input  wire fpu_pkg::fwd_sel_t                  sel,
  input  wire [`FPU_NUM_BUS-1:0][`FPU_DATA_W-1:0] result_bus,
  input  wire [`FPU_DATA_W-1:0]                   self_result,
  output logic [`FPU_DATA_W-1:0]                  operand
);
  import fpu_pkg::*;

  logic [`FPU_NUM_BUS-1:0][`FPU_DATA_W-1:0] bus_q;
  logic [`FPU_DATA_W-1:0]                   self_q;

  // one cycle old copy of every bus, for late picks
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_q  <= '0;
      self_q <= '0;
    end else begin
      bus_q  <= result_bus;
      self_q <= self_result;
    end
  end

  always_comb begin
    case (sel.src)
      src_reg: begin
        operand = reg_val;
      end
      src_bus0: begin
        operand = sel.late ? bus_q[0] : result_bus[0];
      end
      src_bus1: begin
        operand = sel.late ? bus_q[1] : result_bus[1];
      end
      src_self: begin
        operand = sel.late ? self_q : self_result;
      end
      default: begin
        operand = reg_val;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/fpu_decode.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "fpu_config.svh"

module fpu_decode (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    issue_valid,
  input  wire fpu_pkg::fpu_op_t  op,
  input  wire [`FPU_DATA_W-1:0]  a,
  input  wire [`FPU_DATA_W-1:0]  b,
  output fpu_pkg::fpu_ctrl_t     ctrl,
  output logic [`FPU_DATA_W-1:0] a_q,
  output logic [`FPU_DATA_W-1:0] b_q
);
  import fpu_pkg::*;

  fpu_ctrl_t ctrl_d;

  always_comb begin
    ctrl_d         = '0;
    ctrl_d.valid   = issue_valid;
    ctrl_d.unit    = unit_logic;
    ctrl_d.lfn     = lf_and;
    ctrl_d.pfn     = pf_swap;
    ctrl_d.ordered = 1'b0;
    case (op)
      op_or:   ctrl_d.lfn = lf_or;
      op_xor:  ctrl_d.lfn = lf_xor;
      op_andn: ctrl_d.lfn = lf_andn;
      op_swap: begin
        ctrl_d.unit = unit_perm;
        ctrl_d.pfn  = pf_swap;
      end
      op_dup_lo: begin
        ctrl_d.unit = unit_perm;
        ctrl_d.pfn  = pf_dup_lo;
      end
      op_merge: begin
        ctrl_d.unit = unit_perm;
        ctrl_d.pfn  = pf_merge;
      end
      op_cmp_ord: begin
        ctrl_d.unit    = unit_cmp;
        ctrl_d.ordered = 1'b1;
      end
      op_cmp_unord: ctrl_d.unit = unit_cmp;
      // op_and and spare codes
      default: ctrl_d.lfn = lf_and;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl.valid <= 1'b0;
    end else begin
      ctrl.valid <= ctrl_d.valid;
    end
    // fields only move with an issue
    if (issue_valid) begin
      ctrl.unit    <= ctrl_d.unit;
      ctrl.lfn     <= ctrl_d.lfn;
      ctrl.pfn     <= ctrl_d.pfn;
      ctrl.ordered <= ctrl_d.ordered;
      a_q          <= a;
      b_q          <= b;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fp_logic_perm.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "fpu_config.svh"

module fp_logic_perm (
  input  wire fpu_pkg::fpu_ctrl_t ctrl,
  input  wire [`FPU_DATA_W-1:0]   a,
  input  wire [`FPU_DATA_W-1:0]   b,
  output logic [`FPU_DATA_W-1:0]  res
);
  import fpu_pkg::*;

  localparam int HW = `FPU_HALF_W;

  logic [`FPU_DATA_W-1:0] logic_res;
  logic [`FPU_DATA_W-1:0] perm_res;
  logic [HW-1:0]          a_lo;
  logic [HW-1:0]          b_lo;
  logic [HW-1:0]          b_hi;

  assign a_lo = a[HW-1:0];
  assign b_lo = b[HW-1:0];
  assign b_hi = b[`FPU_DATA_W-1:HW];

  always_comb begin
    case (ctrl.lfn)
      lf_and:  logic_res = a & b;
      lf_or:   logic_res = a | b;
      lf_xor:  logic_res = a ^ b;
      lf_andn: logic_res = a & ~b;
      default: logic_res = a & b;
    endcase
  end

  // single lanes taken from b, merge keeps a's low lane
  always_comb begin
    case (ctrl.pfn)
      pf_swap:   perm_res = {b_lo, b_hi};
      pf_dup_lo: perm_res = {b_lo, b_lo};
      pf_merge:  perm_res = {b_hi, a_lo};
      default:   perm_res = b;
    endcase
  end

  assign res = (ctrl.unit == unit_perm) ? perm_res : logic_res;

endmodule

`default_nettype wire

// ==== verilog/fp_compare.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "fpu_config.svh"

module fp_compare (
  input  wire fpu_pkg::fpu_ctrl_t ctrl,
  input  wire [`FPU_DATA_W-1:0]   a,
  input  wire [`FPU_DATA_W-1:0]   b,
  output fpu_pkg::cmp_cc_t        cc,
  output fpu_pkg::fp_flags_t      raised
);
  import fpu_pkg::*;

  localparam int EW = `FPU_EXP_W;
  localparam int FW = `FPU_FRAC_W;
  localparam int MW = `FPU_DATA_W - 1;

  logic          a_sign;
  logic          b_sign;
  logic [EW-1:0] a_exp;
  logic [EW-1:0] b_exp;
  logic [FW-1:0] a_frac;
  logic [FW-1:0] b_frac;
  logic          a_nan;
  logic          b_nan;
  logic          a_snan;
  logic          b_snan;
  logic          a_sub;
  logic          b_sub;
  logic          both_zero;
  logic          mag_lt;
  logic          mag_gt;
  logic          unord;
  logic          eq;
  logic          lt;
  logic          en;

  assign {a_sign, a_exp, a_frac} = a;
  assign {b_sign, b_exp, b_frac} = b;

  assign a_nan  = (&a_exp) & (|a_frac);
  assign b_nan  = (&b_exp) & (|b_frac);
  // quiet bit is the top fraction bit
  assign a_snan = a_nan & ~a_frac[FW-1];
  assign b_snan = b_nan & ~b_frac[FW-1];
  assign a_sub  = ~(|a_exp) & (|a_frac);
  assign b_sub  = ~(|b_exp) & (|b_frac);

  // +0 and -0 compare equal
  assign both_zero = ~(|a[MW-1:0]) & ~(|b[MW-1:0]);
  assign mag_lt    = a[MW-1:0] < b[MW-1:0];
  assign mag_gt    = a[MW-1:0] > b[MW-1:0];

  assign unord = a_nan | b_nan;
  assign eq    = both_zero | (a == b);
  assign lt    = ~eq & ((a_sign & ~b_sign) |
                        (~a_sign & ~b_sign & mag_lt) |
                        (a_sign & b_sign & mag_gt));

  assign en = ctrl.valid & (ctrl.unit == unit_cmp);

  always_comb begin
    cc = '0;
    if (unord) begin
      cc = '{zf: 1'b1, pf: 1'b1, cf: 1'b1};
    end else if (eq) begin
      cc.zf = 1'b1;
    end else if (lt) begin
      cc.cf = 1'b1;
    end
  end

  always_comb begin
    raised          = '0;
    raised.invalid  = en & (a_snan | b_snan | (ctrl.ordered & unord));
    raised.denormal = en & (a_sub | b_sub);
  end

endmodule

`default_nettype wire

// ==== verilog/fpu_except.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "fpu_config.svh"

module fpu_except (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     valid,
  input  wire fpu_pkg::fp_flags_t raised,
  input  wire fpu_pkg::fp_flags_t mask,
  output fpu_pkg::fpu_report_t    report,
  output logic                    report_en
);
  import fpu_pkg::*;

  logic [`FPU_FLAG_W-1:0] unmasked;
  logic                   any_raised;

  // mask bit set means the flag does not trap
  assign unmasked   = raised & ~mask;
  assign any_raised = |raised;

  always_ff @(posedge clk) begin
    if (rst) begin
      report    <= '0;
      report_en <= 1'b0;
    end else begin
      report.flags <= valid ? raised : '0;
      report.trap  <= valid & (|unmasked);
      report_en    <= valid & any_raised;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fpu_lane.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "fpu_config.svh"

module fpu_lane (
  input  wire                                     clk,
  input  wire                                     rst,
  input  wire fpu_pkg::fpu_issue_t                issue,
  input  wire [`FPU_NUM_BUS-1:0][`FPU_DATA_W-1:0] result_bus,
  input  wire [31:0]                              fpcsr,
  output logic [`FPU_DATA_W-1:0]                  result,
  output logic                                    result_valid,
  output fpu_pkg::cmp_cc_t                        cc,
  output fpu_pkg::fpu_report_t                    report,
  output logic                                    report_en
);
  import fpu_pkg::*;

  fpu_issue_t             issue_q;
  logic [`FPU_DATA_W-1:0] opnd_a;
  logic [`FPU_DATA_W-1:0] opnd_b;
  fpu_ctrl_t              ctrl;
  logic [`FPU_DATA_W-1:0] a_q;
  logic [`FPU_DATA_W-1:0] b_q;
  logic [`FPU_DATA_W-1:0] lp_res;
  cmp_cc_t                cmp_cc;
  fp_flags_t              cmp_raised;
  fp_flags_t              exc_mask;

  // issue stage, operands resolve in the following cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_q.valid <= 1'b0;
    end else begin
      issue_q.valid <= issue.valid;
    end
    if (issue.valid) begin
      issue_q.op    <= issue.op;
      issue_q.a     <= issue.a;
      issue_q.b     <= issue.b;
      issue_q.sel_a <= issue.sel_a;
      issue_q.sel_b <= issue.sel_b;
    end
  end

  // the self bus is this lane's result register
  operand_forward a_fwd (
    .clk(clk), .rst(rst), .reg_val(issue_q.a), .sel(issue_q.sel_a),
    .result_bus(result_bus), .self_result(result), .operand(opnd_a)
  );

  operand_forward b_fwd (
    .clk(clk), .rst(rst), .reg_val(issue_q.b), .sel(issue_q.sel_b),
    .result_bus(result_bus), .self_result(result), .operand(opnd_b)
  );

  fpu_decode decode (
    .clk(clk), .rst(rst), .issue_valid(issue_q.valid), .op(issue_q.op),
    .a(opnd_a), .b(opnd_b), .ctrl(ctrl), .a_q(a_q), .b_q(b_q)
  );

  fp_logic_perm logic_perm (.ctrl(ctrl), .a(a_q), .b(b_q), .res(lp_res));

  fp_compare compare (
    .ctrl(ctrl), .a(a_q), .b(b_q), .cc(cmp_cc), .raised(cmp_raised)
  );

  assign exc_mask = fp_flags_t'(fpcsr[`FPU_FLAG_W-1:0]);

  fpu_except except (
    .clk(clk), .rst(rst), .valid(ctrl.valid), .raised(cmp_raised),
    .mask(exc_mask), .report(report), .report_en(report_en)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      result       <= '0;
      cc           <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= ctrl.valid;
      if (ctrl.valid) begin
        // compares only write flags
        if (ctrl.unit == unit_cmp) begin
          result <= '0;
          cc     <= cmp_cc;
        end else begin
          result <= lp_res;
          cc     <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/fpu_lane_tb.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "fpu_config.svh"

module fpu_lane_tb;
  import fpu_pkg::*;

  localparam int PERIOD     = 40;
  localparam int NUM_PATS   = 27;
  localparam int NUM_FIELDS = 12;
  localparam int MEM_DEPTH  = NUM_PATS * NUM_FIELDS;
  localparam int ADDR_W     = $clog2(MEM_DEPTH);
  localparam int IDLE_HEAD  = 3;
  localparam int IDLE_TAIL  = 4;
  // issue edge to the falling edge where the result is sampled
  localparam int PIPE_DEPTH = 3;

  // columns of one pattern line
  localparam int F_OP    = 0;
  localparam int F_A     = 1;
  localparam int F_B     = 2;
  localparam int F_SEL_A = 3;
  localparam int F_SEL_B = 4;
  localparam int F_BUS0  = 5;
  localparam int F_BUS1  = 6;
  localparam int F_MASK  = 7;
  localparam int F_RES   = 8;
  localparam int F_CC    = 9;
  localparam int F_REP   = 10;
  localparam int F_EN    = 11;

  logic                                     clk;
  logic                                     rst;
  fpu_issue_t                               issue;
  logic [`FPU_NUM_BUS-1:0][`FPU_DATA_W-1:0] result_bus;
  logic [31:0]                              fpcsr;
  logic [`FPU_DATA_W-1:0]                   result;
  logic                                     result_valid;
  cmp_cc_t                                  cc;
  fpu_report_t                              report;
  logic                                     report_en;

  logic [63:0] pat_mem [0:MEM_DEPTH-1];
  int          exp_q[$];
  int          errors;
  int          tests_run;
  int          tests_failed;

  fpu_lane UUT (
    .clk(clk), .rst(rst), .issue(issue), .result_bus(result_bus), .fpcsr(fpcsr),
    .result(result), .result_valid(result_valid), .cc(cc), .report(report),
    .report_en(report_en)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [63:0] pat_word(input int idx, input int field);
    logic [ADDR_W-1:0] addr;
    addr = ADDR_W'(idx * NUM_FIELDS + field);
    return pat_mem[addr];
  endfunction

  // line k issues now, its buses follow one cycle later, its mask two
  task automatic drive_cycle(input int k);
    logic [63:0] w;
    if (k >= 0 && k < NUM_PATS) begin
      issue.valid = 1'b1;
      w = pat_word(k, F_OP);
      issue.op = fpu_op_t'(w[`FPU_OP_W-1:0]);
      issue.a = pat_word(k, F_A);
      issue.b = pat_word(k, F_B);
      w = pat_word(k, F_SEL_A);
      issue.sel_a = fwd_sel_t'(w[2:0]);
      w = pat_word(k, F_SEL_B);
      issue.sel_b = fwd_sel_t'(w[2:0]);
      exp_q.push_back(k);
    end else begin
      issue.valid = 1'b0;
      exp_q.push_back(-1);
    end
    if (k - 1 >= 0 && k - 1 < NUM_PATS) begin
      result_bus[0] = pat_word(k - 1, F_BUS0);
      result_bus[1] = pat_word(k - 1, F_BUS1);
    end else begin
      result_bus[0] = {$urandom(), $urandom()};
      result_bus[1] = {$urandom(), $urandom()};
    end
    if (k - 2 >= 0 && k - 2 < NUM_PATS) begin
      w = pat_word(k - 2, F_MASK);
      fpcsr = {27'b0, w[4:0]};
    end else begin
      fpcsr = 32'h0000_001f;
    end
  endtask

  task automatic check_outputs();
    int          idx;
    int          errs_before;
    logic [63:0] w_res;
    logic [63:0] w_cc;
    logic [63:0] w_rep;
    logic [63:0] w_en;
    if (exp_q.size() < PIPE_DEPTH) return;
    idx = exp_q.pop_front();
    if (idx < 0) begin
      assert (result_valid === 1'b0 && report_en === 1'b0) else begin
        $display("Mismatch at %0t: output valid with no operation in flight", $time);
        errors++;
      end
      return;
    end
    errs_before = errors;
    w_res = pat_word(idx, F_RES);
    w_cc  = pat_word(idx, F_CC);
    w_rep = pat_word(idx, F_REP);
    w_en  = pat_word(idx, F_EN);
    assert (result_valid === 1'b1) else begin
      $display("Mismatch at %0t: test %0d result_valid low", $time, idx);
      errors++;
    end
    assert (result === w_res) else begin
      $display("Mismatch at %0t: test %0d result %h, expected %h", $time, idx, result, w_res);
      errors++;
    end
    assert (cc === w_cc[2:0]) else begin
      $display("Mismatch at %0t: test %0d cc %b, expected %b", $time, idx, cc, w_cc[2:0]);
      errors++;
    end
    assert (report === w_rep[5:0]) else begin
      $display("Mismatch at %0t: test %0d report %h, expected %h", $time, idx, report,
               w_rep[5:0]);
      errors++;
    end
    assert (report_en === w_en[0]) else begin
      $display("Mismatch at %0t: test %0d report_en %b, expected %b", $time, idx,
               report_en, w_en[0]);
      errors++;
    end
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d op %0h passed", idx, pat_word(idx, F_OP));
    end else begin
      tests_failed++;
      $display("test %0d op %0h failed", idx, pat_word(idx, F_OP));
    end
  endtask

  initial begin
    void'($urandom(24801));
    $readmemh("dv/fpu_lane_patterns.txt", pat_mem);
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    issue        = '0;
    result_bus   = '0;
    fpcsr        = 32'h0000_001f;

    repeat (4) begin
      @(negedge clk);
      assert (result_valid === 1'b0 && report_en === 1'b0) else begin
        $display("Mismatch at %0t: output valid during reset", $time);
        errors++;
      end
    end
    rst = 1'b0;

    for (int c = 0; c < IDLE_HEAD + NUM_PATS + IDLE_TAIL; c++) begin
      check_outputs();
      drive_cycle(c - IDLE_HEAD);
      @(negedge clk);
    end

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run == NUM_PATS) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((NUM_PATS + 20) * PERIOD);
    $display("Timeout: the run did not complete within %0d cycles", NUM_PATS + 20);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/fpu_lane_patterns.txt ====
// op a b sel_a sel_b bus0 bus1 mask exp_result exp_cc exp_report exp_report_en
// sel is {late, src}, cc is {zf, pf, cf}, report is {flags, trap} with invalid in flags bit 0
0 0123456789abcdef ff00ff00f0f0f0f0 0 0 b0b0b0b0b0b0b000 b1b1b1b1b1b1b100 1f 0100450080a0c0e0 0 00 0
1 0123456789abcdef ff00ff00f0f0f0f0 0 0 b0b0b0b0b0b0b001 b1b1b1b1b1b1b101 1f ff23ff67f9fbfdff 0 00 0
2 0123456789abcdef ff00ff00f0f0f0f0 0 0 b0b0b0b0b0b0b002 b1b1b1b1b1b1b102 1f fe23ba67795b3d1f 0 00 0
3 0123456789abcdef ff00ff00f0f0f0f0 0 0 b0b0b0b0b0b0b003 b1b1b1b1b1b1b103 1f 00230067090b0d0f 0 00 0
4 0123456789abcdef ff00ff00f0f0f0f0 0 0 b0b0b0b0b0b0b004 b1b1b1b1b1b1b104 1f f0f0f0f0ff00ff00 0 00 0
5 ff00ff00f0f0f0f0 0123456789abcdef 0 0 b0b0b0b0b0b0b005 b1b1b1b1b1b1b105 1f 89abcdef89abcdef 0 00 0
6 0123456789abcdef ff00ff00f0f0f0f0 0 0 b0b0b0b0b0b0b006 b1b1b1b1b1b1b106 1f ff00ff0089abcdef 0 00 0
1 0000000000000000 0000000000000000 3 0 b0b0b0b0b0b0b007 b1b1b1b1b1b1b107 1f 89abcdef89abcdef 0 00 0
6 0000000000000000 0000000000000000 1 2 b0b0b0b0b0b0b008 b1b1b1b1b1b1b108 1f b1b1b1b1b0b0b008 0 00 0
2 0000000000000000 0000000000000000 7 3 b0b0b0b0b0b0b009 b1b1b1b1b1b1b109 1f 76ab32ef00000000 0 00 0
6 0000000000000000 0000000000000000 5 6 b0b0b0b0b0b0b00a b1b1b1b1b1b1b10a 1f b1b1b1b1b0b0b009 0 00 0
2 0000000000000000 0000000000000000 2 5 b0b0b0b0b0b0b00b b1b1b1b1b1b1b10b 1f 0101010101010101 0 00 0
8 3ff0000000000000 4000000000000000 0 0 b0b0b0b0b0b0b00c b1b1b1b1b1b1b10c 1f 0000000000000000 1 00 0
7 4000000000000000 3ff0000000000000 0 0 b0b0b0b0b0b0b00d b1b1b1b1b1b1b10d 1f 0000000000000000 0 00 0
7 0000000000000000 8000000000000000 0 0 b0b0b0b0b0b0b00e b1b1b1b1b1b1b10e 1f 0000000000000000 4 00 0
7 3ff0000000000000 3ff0000000000000 0 0 b0b0b0b0b0b0b00f b1b1b1b1b1b1b10f 1f 0000000000000000 4 00 0
7 bff0000000000000 3ff0000000000000 0 0 b0b0b0b0b0b0b010 b1b1b1b1b1b1b110 1f 0000000000000000 1 00 0
7 bff0000000000000 c000000000000000 0 0 b0b0b0b0b0b0b011 b1b1b1b1b1b1b111 1f 0000000000000000 0 00 0
8 7ff8000000000000 3ff0000000000000 0 0 b0b0b0b0b0b0b012 b1b1b1b1b1b1b112 1f 0000000000000000 7 00 0
7 7ff8000000000000 3ff0000000000000 0 0 b0b0b0b0b0b0b013 b1b1b1b1b1b1b113 1f 0000000000000000 7 02 1
7 3ff0000000000000 7ff8000000000000 0 0 b0b0b0b0b0b0b014 b1b1b1b1b1b1b114 1e 0000000000000000 7 03 1
8 7ff0000000000001 3ff0000000000000 0 0 b0b0b0b0b0b0b015 b1b1b1b1b1b1b115 00 0000000000000000 7 03 1
8 0000000000000001 3ff0000000000000 0 0 b0b0b0b0b0b0b016 b1b1b1b1b1b1b116 1f 0000000000000000 1 04 1
7 0000000000000001 0000000000000000 0 0 b0b0b0b0b0b0b017 b1b1b1b1b1b1b117 1d 0000000000000000 0 05 1
3 0123456789abcdef ff00ff00f0f0f0f0 0 0 b0b0b0b0b0b0b018 b1b1b1b1b1b1b118 00 00230067090b0d0f 0 00 0
1 0000000000000000 ff00ff00f0f0f0f0 3 0 b0b0b0b0b0b0b019 b1b1b1b1b1b1b119 1f ff00ff00f0f0f0f0 0 00 0
f 0123456789abcdef ff00ff00f0f0f0f0 0 0 b0b0b0b0b0b0b01a b1b1b1b1b1b1b11a 1f 0100450080a0c0e0 0 00 0

// ==== files.f ====
+incdir+verilog
verilog/fpu_pkg.sv
verilog/operand_forward.sv
verilog/fpu_decode.sv
verilog/fp_logic_perm.sv
verilog/fp_compare.sv
verilog/fpu_except.sv
verilog/fpu_lane.sv
dv/fpu_lane_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fpu_lane testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f files.f \
  --top-module fpu_lane_tb \
  -o fpu_lane_sim

./obj_dir/fpu_lane_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi

echo "simulation PASSED"
exit 0
